// File: include/trace_defines.svh
`ifndef TRACE_DEFINES_SVH
`define TRACE_DEFINES_SVH

// sizing shared by the trace packages and FIFOs

// entries per trace FIFO
// must stay a power of two so the pointers wrap by themselves
`define TRACE_FIFO_DEPTH 4

// register file address width on the core's rd port
`define TRACE_REG_ADDR_W 6

// opcode field values the exec filter looks for
`define TRACE_OP_JAL  7'b1101111
`define TRACE_OP_JALR 7'b1100111

`endif

// File: verilog/core_obs_pkg.sv
`default_nettype none

`include "trace_defines.svh"

// what the tracer sees on the core side
package core_obs_pkg;

	// one retired instruction, 64 bits
	typedef struct packed {
		logic [31:0] pc;	// address of the instruction
		logic [31:0] instr;	// raw encoding
	} retire_t;

	// register file write, 38 bits
	typedef struct packed {
		logic [`TRACE_REG_ADDR_W-1:0] waddr;
		logic [31:0] wdata;
	} reg_write_t;

	// data memory store, 68 bits
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0] strb;	// byte lanes written
	} mem_write_t;

endpackage

`default_nettype wire

// File: verilog/trace_rec_pkg.sv
`default_nettype none

// records leaving the tracer
package trace_rec_pkg;

	// which event a record came from
	typedef enum logic [1:0] {
		rec_exec = 2'd0,	// retired instruction
		rec_reg = 2'd1,	// register write
		rec_mem = 2'd2	// store
	} rec_kind_t;

	// one output record, 70 bits
	// a holds pc, reg address (zero extended) or store address
	// d holds instr, write data or store data
	typedef struct packed {
		rec_kind_t kind;
		logic [31:0] a;
		logic [31:0] d;
		logic [3:0] strb;	// zero unless rec_mem
	} trace_rec_t;

	// empty record, used for the unused fields
	localparam trace_rec_t trace_rec_none = '0;

endpackage

`default_nettype wire

// File: verilog/trace_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

// small sync FIFO, drops new data when full
module trace_fifo #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     rst,
	input  logic     push,
	input  payload_t din,
	input  logic     pop,
	output payload_t dout,
	output logic     avail,
	output logic     drop
);
	localparam int depth = `TRACE_FIFO_DEPTH;
	localparam int ptr_w = $clog2(depth);

	payload_t mem [depth];	// storage
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0] count;	// occupancy, one bit wider than ptr
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (count == (ptr_w+1)'(depth));
	assign avail = (count != '0);
	assign do_push = push && !full;	// full means drop, even with pop
	assign do_pop = pop && avail;

	assign dout = mem[rd_ptr];	// head visible once written

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			drop <= 1'b0;
		end else begin
			drop <= push && full;	// one cycle per lost event
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;	// wraps, depth is 2^n
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/exec_trace_filter.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

// picks which retired instructions get traced
module exec_trace_filter
	import core_obs_pkg::*, trace_rec_pkg::*;
(
	input  logic       clock,
	input  logic       rst,
	input  logic       ret_valid,
	input  logic       trace_all,
	input  retire_t    ret,
	input  logic       pop,
	output trace_rec_t rec,
	output logic       avail,
	output logic       drop
);
	logic [6:0] last_op;	// opcode of previous retire
	logic last_jump;
	logic push;
	retire_t head;

	// previous instruction was a jump, so this one is its target
	assign last_jump = (last_op == `TRACE_OP_JAL) || (last_op == `TRACE_OP_JALR);
	assign push = ret_valid && (trace_all || last_jump);

	always_ff @(posedge clock) begin
		if (rst)
			last_op <= 7'd0;	// not a jump, so first retire is skipped
		else if (ret_valid)
			last_op <= ret.instr[6:0];
	end

	trace_fifo #(.payload_t(retire_t)) u_fifo (
		.clock(clock),
		.rst(rst),
		.push(push),
		.din(ret),
		.pop(pop),
		.dout(head),
		.avail(avail),
		.drop(drop)
	);

	// head as an exec record
	always_comb begin
		rec = trace_rec_none;
		rec.kind = rec_exec;
		rec.a = head.pc;
		rec.d = head.instr;
	end

endmodule

`default_nettype wire

// File: verilog/write_trace_capture.sv
`timescale 1ns/1ps
`default_nettype none

// register writes and stores, offered as one record stream
module write_trace_capture
	import core_obs_pkg::*, trace_rec_pkg::*;
(
	input  logic       clock,
	input  logic       rst,
	input  logic       rd_write,
	input  logic       trace_regs,
	input  logic       mem_valid,
	input  logic       mem_write,
	input  reg_write_t rd,
	input  mem_write_t mw,
	input  logic       pop,
	output trace_rec_t rec,
	output logic       avail,
	output logic       drop
);
	logic reg_push;
	logic reg_pop;
	logic reg_avail;
	logic reg_drop;
	reg_write_t reg_head;
	logic mem_push;
	logic mem_pop;
	logic mem_avail;
	logic mem_drop;
	mem_write_t mem_head;

	assign reg_push = rd_write && trace_regs;	// regs only when enabled
	assign mem_push = mem_valid && mem_write;	// loads ignored

	trace_fifo #(.payload_t(reg_write_t)) u_reg_fifo (
		.clock(clock),
		.rst(rst),
		.push(reg_push),
		.din(rd),
		.pop(reg_pop),
		.dout(reg_head),
		.avail(reg_avail),
		.drop(reg_drop)
	);

	trace_fifo #(.payload_t(mem_write_t)) u_mem_fifo (
		.clock(clock),
		.rst(rst),
		.push(mem_push),
		.din(mw),
		.pop(mem_pop),
		.dout(mem_head),
		.avail(mem_avail),
		.drop(mem_drop)
	);

	// reg side has priority, stores wait behind it
	assign avail = reg_avail || mem_avail;
	assign reg_pop = pop && reg_avail;
	assign mem_pop = pop && !reg_avail;	// fifo ignores pop when empty
	assign drop = reg_drop || mem_drop;

	always_comb begin
		rec = trace_rec_none;
		if (reg_avail) begin
			rec.kind = rec_reg;
			rec.a = 32'(reg_head.waddr);	// zero extend
			rec.d = reg_head.wdata;
		end else begin
			rec.kind = rec_mem;
			rec.a = mem_head.addr;
			rec.d = mem_head.data;
			rec.strb = mem_head.strb;
		end
	end

endmodule

`default_nettype wire

// File: verilog/trace_merge.sv
`timescale 1ns/1ps
`default_nettype none

// merges exec and write sides into the output register
module trace_merge
	import trace_rec_pkg::*;
(
	input  logic       clock,
	input  logic       rst,
	input  trace_rec_t exec_rec,
	input  trace_rec_t wr_rec,
	input  logic       exec_avail,
	input  logic       wr_avail,
	input  logic       exec_drop,
	input  logic       wr_drop,
	output logic       exec_pop,
	output logic       wr_pop,
	output trace_rec_t trace,
	output logic       trace_valid,
	output logic       overflow
);
	logic last_exec;	// exec was served last
	logic pick_exec;
	logic pick_wr;

	// exec wins unless both ready and exec had the last turn
	assign pick_exec = exec_avail && (!wr_avail || !last_exec);
	assign pick_wr = wr_avail && !pick_exec;

	// head leaves its FIFO on the same edge it is registered
	assign exec_pop = pick_exec;
	assign wr_pop = pick_wr;

	// record payload
	always_ff @(posedge clock) begin
		if (pick_exec)
			trace <= exec_rec;
		else if (pick_wr)
			trace <= wr_rec;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			last_exec <= 1'b0;	// exec goes first after reset
			trace_valid <= 1'b0;
		end else begin
			trace_valid <= pick_exec || pick_wr;
			if (pick_exec || pick_wr)
				last_exec <= pick_exec;
		end
	end

	// sticky, only rst clears it
	always_ff @(posedge clock) begin
		if (rst)
			overflow <= 1'b0;
		else if (exec_drop || wr_drop)
			overflow <= 1'b1;
	end

endmodule

`default_nettype wire

// File: verilog/core_tracer.sv
`timescale 1ns/1ps
`default_nettype none

// instruction trace unit, top level
module core_tracer
	import core_obs_pkg::*, trace_rec_pkg::*;
(
	input  logic       clock,
	input  logic       rst,
	input  retire_t    ret,
	input  logic       ret_valid,
	input  reg_write_t rd,
	input  logic       rd_write,
	input  mem_write_t mw,
	input  logic       mem_valid,
	input  logic       mem_write,
	input  logic       trace_all,
	input  logic       trace_regs,
	output trace_rec_t trace,
	output logic       trace_valid,
	output logic       overflow
);
	trace_rec_t exec_rec;	// exec side head
	trace_rec_t wr_rec;	// write side head
	logic exec_avail;
	logic wr_avail;
	logic exec_pop;
	logic wr_pop;
	logic exec_drop;
	logic wr_drop;

	exec_trace_filter u_exec (
		.clock(clock), .rst(rst), .ret_valid(ret_valid), .trace_all(trace_all),
		.ret(ret), .pop(exec_pop), .rec(exec_rec), .avail(exec_avail), .drop(exec_drop)
	);

	write_trace_capture u_wr (
		.clock(clock), .rst(rst), .rd_write(rd_write), .trace_regs(trace_regs),
		.mem_valid(mem_valid), .mem_write(mem_write), .rd(rd), .mw(mw),
		.pop(wr_pop), .rec(wr_rec), .avail(wr_avail), .drop(wr_drop)
	);

	trace_merge u_merge (
		.clock(clock), .rst(rst), .exec_rec(exec_rec), .wr_rec(wr_rec),
		.exec_avail(exec_avail), .wr_avail(wr_avail),
		.exec_drop(exec_drop), .wr_drop(wr_drop),
		.exec_pop(exec_pop), .wr_pop(wr_pop),
		.trace(trace), .trace_valid(trace_valid), .overflow(overflow)
	);

endmodule

`default_nettype wire

// File: testbench/core_tracer_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// output checks on the tracer top level
module core_tracer_assertions
	import trace_rec_pkg::*;
(
	input logic       clock,
	input logic       rst,
	input trace_rec_t trace,
	input logic       trace_valid,
	input logic       overflow
);
	int fails = 0;	// read by the testbench at the end

	// sync reset clears both outputs
	reset_clears: assert property (@(posedge clock) rst |=> (!trace_valid && !overflow))
		else begin
			fails++;
			$error("trace_valid or overflow high in the cycle after rst");
		end

	// sticky until rst
	overflow_sticky: assert property (@(posedge clock) (overflow && !rst) |=> overflow)
		else begin
			fails++;
			$error("overflow fell while rst was low");
		end

	record_known: assert property (@(posedge clock) trace_valid |-> !$isunknown(trace))
		else begin
			fails++;
			$error("trace has unknown bits while trace_valid is high");
		end

endmodule

bind core_tracer core_tracer_assertions u_assertions (
	.clock(clock), .rst(rst), .trace(trace), .trace_valid(trace_valid), .overflow(overflow)
);

`default_nettype wire

// File: testbench/core_tracer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "trace_defines.svh"

// random stimulus against per-kind queues of expected records
module core_tracer_tb
	import core_obs_pkg::*, trace_rec_pkg::*;
();
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam int drain_limit = 200;	// cycles

	logic clock;
	logic rst;
	retire_t ret;
	logic ret_valid;
	reg_write_t rd;
	logic rd_write;
	mem_write_t mw;
	logic mem_valid;
	logic mem_write;
	logic trace_all;
	logic trace_regs;
	trace_rec_t trace;
	logic trace_valid;
	logic overflow;

	trace_rec_t exec_q[$];	// expected, in event order
	trace_rec_t reg_q[$];
	trace_rec_t mem_q[$];
	logic [6:0] last_op;	// previous retired opcode
	bit model_on;	// cleared for the burst, drops break the model
	int errors;
	int checks;
	int seen [3];	// matched records per kind

	core_tracer dut (.*);

	always #2 clock = ~clock;	// 4 ns period

	function automatic trace_rec_t make_rec(rec_kind_t kind, logic [31:0] a,
			logic [31:0] d, logic [3:0] strb);
		trace_rec_t r;
		r.kind = kind;
		r.a = a;
		r.d = d;
		r.strb = strb;
		return r;
	endfunction

	// output record against the head of its kind's queue
	task automatic check_rec(ref trace_rec_t q[$], input trace_rec_t got);
		trace_rec_t exp;
		checks++;
		if (q.size() == 0) begin
			errors++;
			$display("** Error at %0t: unexpected %s record a=%h d=%h", $time,
				got.kind.name(), got.a, got.d);
		end else begin
			exp = q.pop_front();
			if (got !== exp) begin
				errors++;
				$display("** Error at %0t: %s got a=%h d=%h strb=%h, expected a=%h d=%h strb=%h",
					$time, exp.kind.name(), got.a, got.d, got.strb, exp.a, exp.d, exp.strb);
			end else
				seen[int'(got.kind)]++;
		end
	endtask

	// model samples events and output on the rising edge
	always @(posedge clock) begin
		if (rst) begin
			last_op = 7'd0;	// first retire is never a jump target
			exec_q.delete();
			reg_q.delete();
			mem_q.delete();
		end else if (model_on) begin
			if (ret_valid) begin
				if (trace_all || last_op == op_jal || last_op == op_jalr)
					exec_q.push_back(make_rec(rec_exec, ret.pc, ret.instr, 4'h0));
				last_op = ret.instr[6:0];
			end
			if (rd_write && trace_regs)
				reg_q.push_back(make_rec(rec_reg, 32'(rd.waddr), rd.wdata, 4'h0));
			if (mem_valid && mem_write)	// loads give nothing
				mem_q.push_back(make_rec(rec_mem, mw.addr, mw.data, mw.strb));
			if (trace_valid) begin
				case (trace.kind)
					rec_exec: check_rec(exec_q, trace);
					rec_reg: check_rec(reg_q, trace);
					rec_mem: check_rec(mem_q, trace);
					default: begin
						errors++;
						$display("** Error at %0t: record kind %b is not defined",
							$time, trace.kind);
					end
				endcase
			end
		end
	end

	task automatic set_idle();
		ret_valid = 1'b0;
		rd_write = 1'b0;
		mem_valid = 1'b0;
		mem_write = 1'b0;
	endtask

	// one random event cycle, then quiet cycles so nothing drops
	task automatic random_slot(input int quiet);
		logic [31:0] r;
		logic [6:0] op;
		@(negedge clock);
		r = $urandom;
		case (r[2:0])
			3'd0, 3'd1, 3'd2: op = op_jal;
			3'd3, 3'd4, 3'd5: op = op_jalr;
			3'd6: op = 7'b0010011;	// op-imm
			default: op = 7'b0110011;	// reg-reg op
		endcase
		ret.pc = $urandom & 32'hffff_fffc;
		ret.instr = {r[31:7], op};
		ret_valid = ($urandom % 4) != 0;
		rd.waddr = `TRACE_REG_ADDR_W'($urandom);
		rd.wdata = $urandom;
		rd_write = ($urandom % 2) != 0;
		mw.addr = $urandom;
		mw.data = $urandom;
		mw.strb = 4'($urandom);
		mem_valid = ($urandom % 2) != 0;
		mem_write = ($urandom % 2) != 0;	// strobe without write is a load
		repeat (quiet) begin
			@(negedge clock);
			set_idle();
		end
	endtask

	// loop until all queues are empty or the limit runs out
	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while ((exec_q.size() + reg_q.size() + mem_q.size()) != 0 && cycles < drain_limit) begin
			@(negedge clock);
			cycles++;
		end
		if ((exec_q.size() + reg_q.size() + mem_q.size()) != 0) begin
			errors++;
			$display("timed out waiting for the expected records to come out");
		end
		repeat (8) @(negedge clock);	// catch stray records
	endtask

	task automatic apply_reset();
		@(negedge clock);
		rst = 1'b1;
		set_idle();
		repeat (8) @(negedge clock);
		rst = 1'b0;
		model_on = 1'b1;
	endtask

	// all three events every cycle
	task automatic burst(input int n);
		model_on = 1'b0;
		trace_all = 1'b1;
		trace_regs = 1'b1;
		repeat (n) begin
			@(negedge clock);
			ret.pc = $urandom;
			ret.instr = $urandom;
			ret_valid = 1'b1;
			rd_write = 1'b1;
			mem_valid = 1'b1;
			mem_write = 1'b1;
		end
		@(negedge clock);
		set_idle();
	endtask

	initial begin
		int cycles;
		void'($urandom(32'he951_3695));
		clock = 1'b0;
		rst = 1'b1;
		ret = '0;
		rd = '0;
		mw = '0;
		set_idle();
		trace_all = 1'b0;
		trace_regs = 1'b0;
		model_on = 1'b0;
		apply_reset();
		checks++;
		if (trace_valid !== 1'b0 || overflow !== 1'b0) begin
			errors++;
			$display("** Error at %0t: outputs not low after reset", $time);
		end
		// jump targets only, reg writes on
		trace_all = 1'b0;
		trace_regs = 1'b1;
		repeat (40) random_slot(3);
		wait_drain();
		// every instruction, reg writes off
		trace_all = 1'b1;
		trace_regs = 1'b0;
		repeat (40) random_slot(3);
		wait_drain();
		checks++;
		if (overflow !== 1'b0) begin
			errors++;
			$display("** Error at %0t: overflow set at a low event rate", $time);
		end
		burst(20);
		cycles = 0;
		while (overflow !== 1'b1 && cycles < 50) begin
			@(negedge clock);
			cycles++;
		end
		if (overflow !== 1'b1) begin
			errors++;
			$display("overflow did not rise after the burst");
		end
		for (int i = 0; i < 30; i++) begin
			@(negedge clock);
			checks++;
			if (overflow !== 1'b1) begin
				errors++;
				$display("** Error at %0t: overflow fell without a reset", $time);
			end
		end
		apply_reset();
		checks++;
		if (overflow !== 1'b0 || trace_valid !== 1'b0) begin
			errors++;
			$display("** Error at %0t: overflow or trace_valid high after reset", $time);
		end
		for (int k = 0; k < 3; k++) begin
			if (seen[k] == 0) begin
				errors++;
				$display("no records of kind %0d were seen", k);
			end
		end
		if (dut.u_assertions.fails != 0)
			$display("bound assertions failed %0d times", dut.u_assertions.fails);
		errors += dut.u_assertions.fails;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
verilog/core_obs_pkg.sv
verilog/trace_rec_pkg.sv
verilog/trace_fifo.sv
verilog/exec_trace_filter.sv
verilog/write_trace_capture.sv
verilog/trace_merge.sv
verilog/core_tracer.sv
testbench/core_tracer_assertions.sv
testbench/core_tracer_tb.sv
